//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= tb_fetch
FLIST     ?= vlog.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

obj_dir/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/tb_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module tb_fetch
   import ncpu_isa_pkg::*;
   import ncpu_fetch_pkg::*;
();

   localparam int MEM_W = 256;
   localparam int TMO = 400;
   localparam logic [NCPU_PCW-1:0] EPC = 30'd70;
   localparam logic [NCPU_PCW-1:0] FLUSH_TGT = 30'd80;

   logic clk;
   logic rst_n;
   logic ibus_cmd_valid;
   logic ibus_cmd_ready;
   ibus_cmd_t ibus_cmd;
   logic ibus_rsp_valid;
   logic ibus_rsp_ready;
   ibus_rsp_t ibus_rsp;
   logic [NCPU_PCW-1:0] bpu_msr_epc;
   logic specul_flush;
   logic [NCPU_PCW-1:0] specul_tgt_in;
   logic idu_valid;
   logic idu_ready;
   idu_pkt_t idu_pkt;
   logic bpu_wr;
   bpu_upd_t bpu_upd;

   // Program image and MMU fault side table by word address
   logic [NCPU_IW-1:0] prog [MEM_W];
   logic exc_tlb [MEM_W];
   logic exc_pf [MEM_W];
   logic seen [MEM_W];
   logic [1:0] bht_ref [BHT_DEPTH];

   // Bus model state
   logic busy;
   logic [7:0] cur_addr;
   int lat_cnt;
   integer seed = 32'ha612;
   integer rnd;

   // Expected packets in decode order with their squash marks
   idu_pkt_t exp_q [$];
   logic sq_q [$];
   logic [NCPU_PCW-1:0] exp_npc;
   logic flush_arm;
   logic flush_done;
   logic squash_seen;
   logic link_seen;
   int nt_cnt;
   int tk_cnt;
   int errors;
   int checks;
   int tests;
   int err_mark;

   ncpu_fetch_top UUT (
      .clk            (clk),
      .rst_n          (rst_n),
      .ibus_cmd_valid (ibus_cmd_valid),
      .ibus_cmd_ready (ibus_cmd_ready),
      .ibus_cmd       (ibus_cmd),
      .ibus_rsp_valid (ibus_rsp_valid),
      .ibus_rsp_ready (ibus_rsp_ready),
      .ibus_rsp       (ibus_rsp),
      .bpu_msr_epc    (bpu_msr_epc),
      .specul_flush   (specul_flush),
      .specul_tgt_in  (specul_tgt_in),
      .idu_valid      (idu_valid),
      .idu_ready      (idu_ready),
      .idu_pkt        (idu_pkt),
      .bpu_wr         (bpu_wr),
      .bpu_upd        (bpu_upd)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [NCPU_IW-1:0] mk_jmp(input int offs, input logic link);
      logic [31:0] o;
      o = offs;
      return {o[24:0], link, OPC_JMPREL};
   endfunction

   // Expected packet, next fetch PC and redirect flag for one accepted response
   function automatic void next_pc(input logic [NCPU_IW-1:0] insn,
                                   input logic [NCPU_PCW-1:0] pc,
                                   input logic tlb, input logic pf, input logic taken,
                                   input logic flush, input logic [NCPU_PCW-1:0] ftgt,
                                   output idu_pkt_t pkt, output logic [NCPU_PCW-1:0] npc,
                                   output logic redir);
      logic [5:0] opc;
      logic [NCPU_PCW-1:0] rel;
      logic [NCPU_PCW-1:0] vec;
      logic ext;
      logic br;
      logic kill;
      opc = insn[5:0];
      rel = pc + {{5{insn[31]}}, insn[31:7]};
      ext = tlb | pf;
      vec = tlb ? 30'd32 : 30'd48;
      br = (opc == 6'd2) || (opc == 6'd3);
      kill = flush | ext | (opc == 6'd4);
      redir = 1'b1;
      if (flush) npc = ftgt;
      else if (ext) npc = vec;
      else if (opc == 6'd4) npc = 30'd16;
      else if (opc == 6'd5) npc = EPC;
      else if (opc == 6'd1) npc = rel;
      else if (br && taken) npc = rel;
      else begin
         npc = pc + 1'b1;
         redir = 1'b0;
      end
      pkt = '0;
      pkt.insn = kill ? '0 : insn;
      pkt.pc = pc;
      pkt.op_jmprel = (opc == 6'd1) & ~kill;
      pkt.jmprel_link = (opc == 6'd1) & insn[6] & ~kill;
      pkt.specul_jmprel = br & ~kill;
      pkt.op_syscall = (opc == 6'd4) & ~(flush | ext);
      pkt.op_ret = (opc == 6'd5) & ~(flush | ext);
      // BT predicts the flag set when taken and BCC predicts it clear
      pkt.specul_bcc = (opc == 6'd3) ? taken : ((opc == 6'd2) ? ~taken : 1'b0);
      pkt.specul_extexp = ext;
      pkt.let_lsa_pc = ext;
      if (ext) pkt.specul_tgt = vec;
      else if (opc == 6'd4) pkt.specul_tgt = 30'd16;
      else if (opc == 6'd5) pkt.specul_tgt = EPC;
      else if (br) pkt.specul_tgt = taken ? pc + 1'b1 : rel;
      else pkt.specul_tgt = '0;
   endfunction

   task automatic check_val(input string name, input logic [31:0] e, input logic [31:0] g);
      checks++;
      assert (e === g) else begin
         $display("FAILED %0t %s expected %h actual %h", $time, name, e, g);
         errors++;
      end
   endtask

   // Response side, decode side, predictor mirror and bus state update at the rising edge
   always @(posedge clk) begin
      idu_pkt_t ep;
      logic [NCPU_PCW-1:0] np;
      logic tk;
      logic rd;
      logic [7:0] a;
      if (rst_n) begin
         if (ibus_rsp_valid && ibus_rsp_ready) begin
            a = ibus_rsp.addr[9:2];
            tk = bht_ref[a[3:0]][1];
            check_val("ibus_rsp.addr", {exp_npc, 2'b00}, ibus_rsp.addr);
            next_pc(ibus_rsp.insn, {22'd0, a}, ibus_rsp.tlb_miss, ibus_rsp.page_fault, tk,
                    specul_flush, specul_tgt_in, ep, np, rd);
            if (a == 8'd60 && tk) tk_cnt++;
            if (a == 8'd60 && !tk) nt_cnt++;
            exp_q.push_back(ep);
            sq_q.push_back(specul_flush);
            exp_npc = np;
            busy = 1'b0;
         end else begin
            // Only a flush pulse steers fetch without a response
            rd = specul_flush;
            np = specul_tgt_in;
            if (specul_flush) begin
               exp_npc = specul_tgt_in;
            end
         end
         // A redirect leaves as a flush command to the target word
         if (ibus_cmd_valid) begin
            check_val("ibus_cmd.flush", rd, ibus_cmd.flush);
            if (rd) begin
               check_val("ibus_cmd.addr", {np, 2'b00}, ibus_cmd.addr);
            end
         end
         // A stalled packet blocks the next bus response
         if (idu_valid && !idu_ready) begin
            check_val("ibus_rsp_ready", 1'b0, ibus_rsp_ready);
         end
         if (idu_valid && idu_ready) begin
            assert (exp_q.size() > 0) else begin
               $display("Decode got a packet at %0t that no bus response produced", $time);
               errors++;
            end
            if (exp_q.size() > 0) begin
               ep = exp_q.pop_front();
               if (sq_q.pop_front()) squash_seen = 1'b1;
               check_val("idu_pkt.pc", ep.pc, idu_pkt.pc);
               check_val("idu_pkt.insn", ep.insn, idu_pkt.insn);
               check_val("idu_pkt.op_jmprel", ep.op_jmprel, idu_pkt.op_jmprel);
               check_val("idu_pkt.jmprel_link", ep.jmprel_link, idu_pkt.jmprel_link);
               check_val("idu_pkt.op_syscall", ep.op_syscall, idu_pkt.op_syscall);
               check_val("idu_pkt.op_ret", ep.op_ret, idu_pkt.op_ret);
               check_val("idu_pkt.specul_jmprel", ep.specul_jmprel, idu_pkt.specul_jmprel);
               check_val("idu_pkt.specul_tgt", ep.specul_tgt, idu_pkt.specul_tgt);
               check_val("idu_pkt.specul_bcc", ep.specul_bcc, idu_pkt.specul_bcc);
               check_val("idu_pkt.specul_extexp", ep.specul_extexp, idu_pkt.specul_extexp);
               check_val("idu_pkt.let_lsa_pc", ep.let_lsa_pc, idu_pkt.let_lsa_pc);
               if (idu_pkt.jmprel_link) link_seen = 1'b1;
               seen[idu_pkt.pc[7:0]] = 1'b1;
            end
         end
         // Mirror of the saturating counters
         if (bpu_wr) begin
            a = {4'd0, bpu_upd.pc[3:0]};
            if (bpu_upd.taken && bht_ref[a] != 2'd3) bht_ref[a] = bht_ref[a] + 2'd1;
            if (!bpu_upd.taken && bht_ref[a] != 2'd0) bht_ref[a] = bht_ref[a] - 2'd1;
         end
         // One outstanding command where a flush replaces the pending one
         if (ibus_cmd_valid && (ibus_cmd.flush || ibus_cmd_ready)) begin
            busy = 1'b1;
            cur_addr = ibus_cmd.addr[9:2];
            lat_cnt = {$random(seed)} % 3;
         end else if (busy && lat_cnt > 0) begin
            lat_cnt--;
         end
      end
   end

   // Bus and decode drivers on the falling edge
   always @(negedge clk) begin
      if (!rst_n) begin
         ibus_cmd_ready = 1'b0;
         ibus_rsp_valid = 1'b0;
         idu_ready = 1'b0;
         specul_flush = 1'b0;
      end else begin
         rnd = $random(seed);
         ibus_cmd_ready = ~busy;
         ibus_rsp_valid = busy && (lat_cnt == 0);
         ibus_rsp.insn = prog[cur_addr];
         ibus_rsp.addr = {22'd0, cur_addr, 2'b00};
         ibus_rsp.tlb_miss = exc_tlb[cur_addr];
         ibus_rsp.page_fault = exc_pf[cur_addr];
         idu_ready = rnd[0] | rnd[1];
         specul_flush = 1'b0;
         // Fire the flush onto a response that is taken in the same cycle
         if (flush_arm && ibus_rsp_valid) begin
            specul_flush = 1'b1;
            specul_tgt_in = FLUSH_TGT;
            idu_ready = 1'b1;
            flush_arm = 1'b0;
            flush_done = 1'b1;
         end
      end
   end

   task automatic wait_seen(input int pc);
      int n;
      for (n = 0; n < TMO && !seen[pc]; n++) @(negedge clk);
      if (!seen[pc]) begin
         $display("Timed out waiting for a decoded packet at word %0d", pc);
         errors++;
      end
   endtask

   task automatic train_taken(input logic [NCPU_PCW-1:0] pc);
      repeat (2) begin
         @(negedge clk);
         bpu_wr = 1'b1;
         bpu_upd.pc = pc;
         bpu_upd.taken = 1'b1;
      end
      @(negedge clk);
      bpu_wr = 1'b0;
   endtask

   task automatic report_test(input string name);
      tests++;
      $display("test %0d %s: %s", tests, name, (errors == err_mark) ? "ok" : "failed");
      err_mark = errors;
   endtask

   initial begin
      int i;
      int n;
      rst_n = 1'b0;
      ibus_cmd_ready = 1'b0;
      ibus_rsp_valid = 1'b0;
      ibus_rsp = '0;
      bpu_msr_epc = EPC;
      specul_flush = 1'b0;
      specul_tgt_in = '0;
      idu_ready = 1'b0;
      bpu_wr = 1'b0;
      bpu_upd = '0;
      busy = 1'b0;
      cur_addr = '0;
      lat_cnt = 0;
      exp_npc = vec_to_pc(VEC_RESET);
      flush_arm = 1'b0;
      flush_done = 1'b0;
      squash_seen = 1'b0;
      link_seen = 1'b0;
      nt_cnt = 0;
      tk_cnt = 0;
      errors = 0;
      checks = 0;
      tests = 0;
      err_mark = 0;
      // Plain words carry address-dependent bits and opcode 0x30
      for (i = 0; i < MEM_W; i++) begin
         prog[i] = {(25'(i) * 25'd977) ^ 25'h0A5A5A, 1'b1, 6'h30};
         exc_tlb[i] = 1'b0;
         exc_pf[i] = 1'b0;
         seen[i] = 1'b0;
      end
      for (i = 0; i < BHT_DEPTH; i++) bht_ref[i] = 2'd1;
      prog[6] = mk_jmp(4, 1'b0);
      prog[10] = mk_jmp(50, 1'b1);
      prog[60] = {25'd8, 1'b0, OPC_BCC};
      prog[62] = mk_jmp(-2, 1'b0);
      prog[68] = {25'h12345, 1'b0, OPC_SYSCALL};
      prog[17] = {25'd0, 1'b0, OPC_RET};
      exc_tlb[71] = 1'b1;
      exc_pf[33] = 1'b1;
      prog[52] = mk_jmp(0, 1'b0);
      prog[84] = mk_jmp(0, 1'b0);

      // Outputs stay quiet while reset is held for 4 cycles
      for (i = 0; i < 4; i++) begin
         @(negedge clk);
         assert (!idu_valid && !ibus_cmd_valid) else begin
            $display("Valid strobe high at %0t while reset is held", $time);
            errors++;
         end
      end
      rst_n = 1'b1;
      for (n = 0; n < 20 && !ibus_cmd_valid; n++) @(negedge clk);
      if (!ibus_cmd_valid) begin
         $display("No fetch command issued after reset");
         errors++;
      end else begin
         check_val("ibus_cmd.addr", {24'd0, VEC_RESET}, ibus_cmd.addr);
      end
      report_test("reset");

      wait_seen(6);
      report_test("straight program");

      wait_seen(60);
      assert (link_seen) else begin
         $display("No packet with the jmprel link flag reached decode");
         errors++;
      end
      report_test("relative jumps");

      train_taken(30'd60);
      wait_seen(68);
      assert (nt_cnt > 0 && tk_cnt > 0) else begin
         $display("Branch at word 60 was not seen both not taken and taken");
         errors++;
      end
      report_test("branch prediction");

      wait_seen(48);
      assert (seen[17] && seen[70] && seen[71] && seen[33]) else begin
         $display("Syscall, ret or MMU exception path was skipped");
         errors++;
      end
      report_test("syscall ret exceptions");

      @(posedge clk);
      flush_arm = 1'b1;
      for (n = 0; n < TMO && !flush_done; n++) @(negedge clk);
      if (!flush_done) begin
         $display("Flush pulse never met a bus response");
         errors++;
      end
      wait_seen(84);
      assert (squash_seen) else begin
         $display("No packet accepted in the flush cycle reached decode");
         errors++;
      end
      report_test("speculative flush");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/ncpu_bpu.sv
`timescale 1ns/100ps
`default_nettype none

module ncpu_bpu
   import ncpu_isa_pkg::*;
   import ncpu_fetch_pkg::*;
(
   input wire logic clk,
   input wire logic rst_n,
   input wire logic bpu_rd,
   input wire bpu_req_t bpu_req,
   output logic bpu_taken,
   input wire logic bpu_wr,
   input wire bpu_upd_t bpu_upd
);

   // Two-bit saturating counters
   logic [1:0] bht_q [BHT_DEPTH];
   logic [BHT_IDX_W-1:0] rd_idx;
   logic [BHT_IDX_W-1:0] wr_idx;
   logic [1:0] wr_cnt;

   // Low word bits select the entry
   assign rd_idx = bpu_req.pc[BHT_IDX_W-1:0];
   assign wr_idx = bpu_upd.pc[BHT_IDX_W-1:0];
   assign wr_cnt = bht_q[wr_idx];

   // Lookup, MSB of the counter gives the direction
   assign bpu_taken = bpu_rd & bht_q[rd_idx][1];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // All entries start weakly not taken
         for (int i = 0; i < BHT_DEPTH; i++) begin
            bht_q[i] <= 2'b01;
         end
      end else if (bpu_wr) begin
         if (bpu_upd.taken) begin
            // Count up, stop at strongly taken
            if (wr_cnt != 2'b11) begin
               bht_q[wr_idx] <= wr_cnt + 2'd1;
            end
         end else begin
            // Count down, stop at strongly not taken
            if (wr_cnt != 2'b00) begin
               bht_q[wr_idx] <= wr_cnt - 2'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- verilog/ncpu_fetch_pkg.sv
`default_nettype none

package ncpu_fetch_pkg;

   import ncpu_isa_pkg::*;

   // Idle cycles after reset before the first fetch
   localparam int IFU_RST_WAIT = 2;
   localparam int IFU_RST_CW = $clog2(IFU_RST_WAIT + 1);

   // Fetch command, flush also discards the pending response
   typedef struct packed {
      logic [NCPU_AW-1:0] addr;
      logic flush;
   } ibus_cmd_t;

   // Instruction response with its byte address and MMU status
   typedef struct packed {
      logic [NCPU_IW-1:0] insn;
      logic [NCPU_AW-1:0] addr;
      logic tlb_miss;
      logic page_fault;
   } ibus_rsp_t;

   // Predecoded operation class, at most one op flag set
   typedef struct packed {
      logic op_jmprel;
      logic jmprel_link;
      logic op_bcc;
      logic op_bt;
      logic op_syscall;
      logic op_ret;
      logic [NCPU_PCW-1:0] offset;
   } predec_t;

   typedef struct packed {
      logic [NCPU_PCW-1:0] pc;
   } bpu_req_t;

   // Resolved branch outcome from execute
   typedef struct packed {
      logic [NCPU_PCW-1:0] pc;
      logic taken;
   } bpu_upd_t;

   // Packet handed to decode
   typedef struct packed {
      logic [NCPU_IW-1:0] insn;
      logic [NCPU_PCW-1:0] pc;
      logic op_jmprel;
      logic jmprel_link;
      logic op_syscall;
      logic op_ret;
      logic specul_jmprel;
      logic [NCPU_PCW-1:0] specul_tgt;
      logic specul_bcc;
      logic specul_extexp;
      logic let_lsa_pc;
   } idu_pkt_t;

endpackage

`default_nettype wire

//--- verilog/ncpu_fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

module ncpu_fetch_top
   import ncpu_isa_pkg::*;
   import ncpu_fetch_pkg::*;
(
   input wire logic clk,
   input wire logic rst_n,
   output logic ibus_cmd_valid,
   input wire logic ibus_cmd_ready,
   output ibus_cmd_t ibus_cmd,
   input wire logic ibus_rsp_valid,
   output logic ibus_rsp_ready,
   input wire ibus_rsp_t ibus_rsp,
   input wire logic [NCPU_PCW-1:0] bpu_msr_epc,
   input wire logic specul_flush,
   input wire logic [NCPU_PCW-1:0] specul_tgt_in,
   output logic idu_valid,
   input wire logic idu_ready,
   output idu_pkt_t idu_pkt,
   input wire logic bpu_wr,
   input wire bpu_upd_t bpu_upd
);

   // Lookup path between fetch and predictor
   logic bpu_rd;
   bpu_req_t bpu_req;
   logic bpu_taken;

   ncpu_ifu u_ifu (
      .clk            (clk),
      .rst_n          (rst_n),
      .ibus_cmd_valid (ibus_cmd_valid),
      .ibus_cmd_ready (ibus_cmd_ready),
      .ibus_cmd       (ibus_cmd),
      .ibus_rsp_valid (ibus_rsp_valid),
      .ibus_rsp_ready (ibus_rsp_ready),
      .ibus_rsp       (ibus_rsp),
      .bpu_rd         (bpu_rd),
      .bpu_req        (bpu_req),
      .bpu_taken      (bpu_taken),
      .bpu_msr_epc    (bpu_msr_epc),
      .specul_flush   (specul_flush),
      .specul_tgt_in  (specul_tgt_in),
      .idu_valid      (idu_valid),
      .idu_ready      (idu_ready),
      .idu_pkt        (idu_pkt)
   );

   // Training comes straight from execute
   ncpu_bpu u_bpu (
      .clk       (clk),
      .rst_n     (rst_n),
      .bpu_rd    (bpu_rd),
      .bpu_req   (bpu_req),
      .bpu_taken (bpu_taken),
      .bpu_wr    (bpu_wr),
      .bpu_upd   (bpu_upd)
   );

endmodule

`default_nettype wire

//--- verilog/ncpu_ifu.sv
`timescale 1ns/100ps
`default_nettype none

module ncpu_ifu
   import ncpu_isa_pkg::*;
   import ncpu_fetch_pkg::*;
(
   input wire logic clk,
   input wire logic rst_n,
   output logic ibus_cmd_valid,
   input wire logic ibus_cmd_ready,
   output ibus_cmd_t ibus_cmd,
   input wire logic ibus_rsp_valid,
   output logic ibus_rsp_ready,
   input wire ibus_rsp_t ibus_rsp,
   output logic bpu_rd,
   output bpu_req_t bpu_req,
   input wire logic bpu_taken,
   input wire logic [NCPU_PCW-1:0] bpu_msr_epc,
   input wire logic specul_flush,
   input wire logic [NCPU_PCW-1:0] specul_tgt_in,
   output logic idu_valid,
   input wire logic idu_ready,
   output idu_pkt_t idu_pkt
);

   logic [IFU_RST_CW-1:0] rst_cnt_q;
   logic fetch_en;
   logic [NCPU_PCW-1:0] fetch_pc_q;
   logic [NCPU_PCW-1:0] cmd_pc;
   logic [NCPU_PCW-1:0] redir_pc;
   logic redirect;
   logic buf_in_ready;
   logic hds_rsp;
   logic hds_cmd;
   predec_t pd;
   logic [NCPU_PCW-1:0] rsp_pc;
   logic [NCPU_PCW-1:0] seq_pc;
   logic [NCPU_PCW-1:0] rel_tgt;
   logic [NCPU_PCW-1:0] exp_pc;
   logic ext_tlb;
   logic ext_pf;
   logic extexp;
   logic is_branch;
   logic br_taken;
   logic not_flushing;
   logic not_flushing_intexp;
   idu_pkt_t pkt_nxt;

   // Hold off the bus for a few cycles after reset
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rst_cnt_q <= '0;
      end else if (!fetch_en) begin
         rst_cnt_q <= rst_cnt_q + 1'b1;
      end
   end

   assign fetch_en = (rst_cnt_q == IFU_RST_CW'(IFU_RST_WAIT));

   // Response accepted only when the packet buffer has room
   assign ibus_rsp_ready = fetch_en & buf_in_ready;
   assign hds_rsp = ibus_rsp_valid & ibus_rsp_ready;
   assign hds_cmd = ibus_cmd_valid & ibus_cmd_ready;

   ncpu_ipdu u_ipdu (
      .insn   (ibus_rsp.insn),
      .predec (pd)
   );

   // Addresses relative to the returned word
   assign rsp_pc = ibus_rsp.addr[NCPU_AW-1:2];
   assign seq_pc = rsp_pc + 1'b1;
   assign rel_tgt = rsp_pc + pd.offset;

   // MMU exceptions come with the response
   assign ext_tlb = hds_rsp & ibus_rsp.tlb_miss;
   assign ext_pf = hds_rsp & ibus_rsp.page_fault;
   assign extexp = ext_tlb | ext_pf;

   // Vector for external exceptions or syscall
   assign exp_pc = ext_tlb ? vec_to_pc(VEC_ITLB_MISS) :
                   ext_pf ? vec_to_pc(VEC_IPAGE_FAULT) :
                   vec_to_pc(VEC_SYSCALL);

   // Predictor lookup for every accepted conditional branch
   assign is_branch = hds_rsp & (pd.op_bcc | pd.op_bt);
   assign bpu_rd = is_branch;
   assign bpu_req = '{pc: rsp_pc};
   assign br_taken = is_branch & bpu_taken;

   // Next fetch target, highest priority first
   always_comb begin
      redirect = 1'b1;
      if (specul_flush) begin
         redir_pc = specul_tgt_in;
      end else if (extexp || (hds_rsp && pd.op_syscall)) begin
         redir_pc = exp_pc;
      end else if (hds_rsp && pd.op_ret) begin
         redir_pc = bpu_msr_epc;
      end else if ((hds_rsp && pd.op_jmprel) || br_taken) begin
         redir_pc = rel_tgt;
      end else begin
         redirect = 1'b0;
         redir_pc = seq_pc;
      end
      // Nothing to redirect during the reset wait
      redirect = redirect & fetch_en;
   end

   // Flush command fetches the target and drops the bus's pending response
   assign cmd_pc = redirect ? redir_pc : fetch_pc_q;
   assign ibus_cmd_valid = fetch_en;
   assign ibus_cmd = '{addr: {cmd_pc, 2'b00}, flush: redirect};

   // Fetch PC, a flush is always taken by the bus
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         fetch_pc_q <= vec_to_pc(VEC_RESET);
      end else if (redirect) begin
         fetch_pc_q <= redir_pc + 1'b1;
      end else if (hds_cmd) begin
         fetch_pc_q <= fetch_pc_q + 1'b1;
      end
   end

   // Squash rules for the outgoing packet
   assign not_flushing = ~(specul_flush | extexp | pd.op_syscall);
   assign not_flushing_intexp = ~(specul_flush | extexp);

   always_comb begin
      pkt_nxt.insn = not_flushing ? ibus_rsp.insn : '0;
      pkt_nxt.pc = rsp_pc;
      pkt_nxt.op_jmprel = pd.op_jmprel & not_flushing;
      pkt_nxt.jmprel_link = pd.jmprel_link & not_flushing;
      pkt_nxt.specul_jmprel = (pd.op_bcc | pd.op_bt) & not_flushing;
      pkt_nxt.op_syscall = pd.op_syscall & not_flushing_intexp;
      pkt_nxt.op_ret = pd.op_ret & not_flushing_intexp;
      // Predicted condition flag, BCC taken means flag clear
      pkt_nxt.specul_bcc = (bpu_taken & pd.op_bt) | (~bpu_taken & pd.op_bcc);
      pkt_nxt.specul_extexp = extexp;
      // ELSA gets the faulting PC
      pkt_nxt.let_lsa_pc = extexp;
      // Recovery target, the path not predicted
      if (extexp || pd.op_syscall) begin
         pkt_nxt.specul_tgt = exp_pc;
      end else if (pd.op_ret) begin
         pkt_nxt.specul_tgt = bpu_msr_epc;
      end else if (pd.op_bcc || pd.op_bt) begin
         pkt_nxt.specul_tgt = bpu_taken ? seq_pc : rel_tgt;
      end else begin
         pkt_nxt.specul_tgt = '0;
      end
   end

   ncpu_pipebuf #(.payload_t(idu_pkt_t)) u_pipebuf (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_valid  (ibus_rsp_valid & fetch_en),
      .in_ready  (buf_in_ready),
      .din       (pkt_nxt),
      .out_valid (idu_valid),
      .out_ready (idu_ready),
      .dout      (idu_pkt)
   );

   // Bus must not raise both MMU faults on one response
   a_one_extexp: assert property (@(posedge clk) disable iff (!rst_n)
      hds_rsp |-> $onehot0({ibus_rsp.tlb_miss, ibus_rsp.page_fault}));

   // jmprel and conditional branch never steer the same word
   a_jmp_excl: assert property (@(posedge clk) disable iff (!rst_n)
      hds_rsp |-> !(pd.op_jmprel && (pd.op_bcc || pd.op_bt)));

endmodule

`default_nettype wire

//--- verilog/ncpu_ipdu.sv
`timescale 1ns/100ps
`default_nettype none

module ncpu_ipdu
   import ncpu_isa_pkg::*;
   import ncpu_fetch_pkg::*;
(
   input wire logic [NCPU_IW-1:0] insn,
   output predec_t predec
);

   logic [OPC_W-1:0] opc;

   assign opc = insn[OPC_W-1:0];

   always_comb begin
      // Opcode compare, one flag per control-flow class
      predec.op_jmprel = (opc == OPC_JMPREL);
      predec.op_bcc = (opc == OPC_BCC);
      predec.op_bt = (opc == OPC_BT);
      predec.op_syscall = (opc == OPC_SYSCALL);
      predec.op_ret = (opc == OPC_RET);
      // Link only has meaning for jmprel
      predec.jmprel_link = predec.op_jmprel & insn[JMPREL_LINK_BIT];
      // Sign-extend the word offset to PC width
      predec.offset = {{(NCPU_PCW-OFFS_W){insn[NCPU_IW-1]}}, insn[NCPU_IW-1:OFFS_LSB]};
   end

   // Opcodes decode to distinct classes
   always_comb begin
      if (!$isunknown(insn)) begin
         a_onehot_ops: assert #0 ($onehot0({predec.op_jmprel, predec.op_bcc, predec.op_bt,
                                            predec.op_syscall, predec.op_ret}));
      end
   end

endmodule

`default_nettype wire

//--- verilog/ncpu_isa_pkg.sv
`default_nettype none

package ncpu_isa_pkg;

   // Datapath widths
   localparam int NCPU_AW = 32;
   localparam int NCPU_IW = 32;
   // Program counters count words, not bytes
   localparam int NCPU_PCW = NCPU_AW - 2;

   // Opcode field in insn[5:0]
   localparam int OPC_W = 6;
   localparam logic [OPC_W-1:0] OPC_JMPREL = 6'd1;
   localparam logic [OPC_W-1:0] OPC_BCC = 6'd2;
   localparam logic [OPC_W-1:0] OPC_BT = 6'd3;
   localparam logic [OPC_W-1:0] OPC_SYSCALL = 6'd4;
   localparam logic [OPC_W-1:0] OPC_RET = 6'd5;

   // Link flag of jmprel, then signed word offset up to the MSB
   localparam int JMPREL_LINK_BIT = 6;
   localparam int OFFS_LSB = 7;
   localparam int OFFS_W = NCPU_IW - OFFS_LSB;

   // Byte vectors of the exception entries
   localparam logic [7:0] VEC_RESET = 8'h00;
   localparam logic [7:0] VEC_SYSCALL = 8'h40;
   localparam logic [7:0] VEC_ITLB_MISS = 8'h80;
   localparam logic [7:0] VEC_IPAGE_FAULT = 8'hC0;

   // BHT indexed by the low word address bits
   localparam int BHT_IDX_W = 4;
   localparam int BHT_DEPTH = 1 << BHT_IDX_W;

   // Byte vector to word address
   function automatic logic [NCPU_PCW-1:0] vec_to_pc(input logic [7:0] vec);
      return {{(NCPU_PCW-6){1'b0}}, vec[7:2]};
   endfunction

endpackage

`default_nettype wire

//--- verilog/ncpu_pipebuf.sv
`timescale 1ns/100ps
`default_nettype none

module ncpu_pipebuf #(
   parameter type payload_t = logic
) (
   input wire logic clk,
   input wire logic rst_n,
   input wire logic in_valid,
   output logic in_ready,
   input wire payload_t din,
   output logic out_valid,
   input wire logic out_ready,
   output payload_t dout
);

   logic valid_q;
   payload_t data_q;

   // Take new data when empty or when the held item leaves this cycle
   assign in_ready = ~valid_q | out_ready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else if (in_ready) begin
         valid_q <= in_valid;
      end
   end

   // Payload register
   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         data_q <= din;
      end
   end

   assign out_valid = valid_q;
   assign dout = data_q;

   // A stalled item stays put until the consumer takes it
   a_hold_stable: assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(dout));

endmodule

`default_nettype wire

//--- vlog.f
verilog/ncpu_isa_pkg.sv
verilog/ncpu_fetch_pkg.sv
verilog/ncpu_pipebuf.sv
verilog/ncpu_ipdu.sv
verilog/ncpu_bpu.sv
verilog/ncpu_ifu.sv
verilog/ncpu_fetch_top.sv
tb/tb_fetch.sv
